/* project.f */
+incdir+source
source/rv_pkg.sv
source/bus_arbiter.sv
source/fetch_unit.sv
source/decode_regfile.sv
source/execute_unit.sv
source/mem_writeback.sv
source/rv_core.sv
tb/tb_memory.sv
tb/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - source
    files:
      - source/rv_pkg.sv
      - source/bus_arbiter.sv
      - source/fetch_unit.sv
      - source/decode_regfile.sv
      - source/execute_unit.sv
      - source/mem_writeback.sv
      - source/rv_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_memory.sv
      - tb/rv_core_tb.sv

/* tb/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_tb;
	import rv_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 4;
	localparam int RUN_LIMIT    = 100;   // worst case for one program
	localparam int DRAIN_CYCLES = 8;
	localparam int NUM_TESTS    = 5;
	localparam int WATCHDOG_CYCLES =
		4 * NUM_TESTS * (RESET_CYCLES + 2 + RUN_LIMIT + DRAIN_CYCLES);

	logic     clock;
	logic     rst;
	xlen_t    mem_rdata, mem_addr, mem_wdata;
	mem_cmd_e mem_command;
	logic     commit_valid, commit_wr_en;
	reg_idx_t commit_wr_idx;
	xlen_t    commit_wr_data, commit_pc;
	error_e   error_status;

	int          errors;
	int          checks;
	int unsigned seed;
	string       current_test;
	inst_t       prog[$];
	xlen_t       ref_mem [`MEM_WORDS];   // memory as the model leaves it
	xlen_t       exp_pc[$], exp_data[$], got_pc[$], got_data[$];
	reg_idx_t    exp_idx[$], got_idx[$];
	error_e      exp_status;

	rv_core DUT (.*);

	tb_memory mem_model (
		.clock   (clock),
		.command (mem_command),
		.addr    (mem_addr),
		.wdata   (mem_wdata),
		.rdata   (mem_rdata)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired at %0t, the tests did not complete", $time);
		$display("Verification failed");
		$finish;
	end

	// commit monitor, x0 writes count as no write
	always @(posedge clock) begin
		if (!rst && commit_valid) begin
			got_pc.push_back(commit_pc);
			got_idx.push_back(commit_wr_en ? commit_wr_idx : `ZERO_REG);
			got_data.push_back(commit_wr_data);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input xlen_t actual, input xlen_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h (%s)",
			         $time, name, actual, expected, current_test);
		end
	endtask

	task automatic check_idx(input string name, input reg_idx_t actual,
	                         input reg_idx_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t: %s is x%0d, expected x%0d (%s)",
			         $time, name, actual, expected, current_test);
		end
	endtask

	task automatic check_status(input string name, input error_e actual, input error_e expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t: %s is %s, expected %s (%s)",
			         $time, name, actual.name(), expected.name(), current_test);
		end
	endtask

	task automatic check_cmd(input string name, input mem_cmd_e actual, input mem_cmd_e expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t: %s is %s, expected %s (%s)",
			         $time, name, actual.name(), expected.name(), current_test);
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b (%s)",
			         $time, name, actual, expected, current_test);
		end
	endtask

	task automatic check_idle;
		check_flag("commit_valid", commit_valid, 1'b0);
		check_cmd("mem_command", mem_command, BUS_NONE);
		check_status("error_status", error_status, NO_ERROR);
	endtask

	//////////////////////////////////////////////////////////////////////
	// instruction encoders
	//////////////////////////////////////////////////////////////////////

	function automatic inst_t r_type(input logic [6:0] f7, input logic [2:0] f3,
	                                 input int rd, input int rs1, input int rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPC_OP};
	endfunction

	function automatic inst_t addi(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], `F3_ADD, rd[4:0], `OPC_OP_IMM};
	endfunction

	function automatic inst_t lw(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], `F3_WORD, rd[4:0], `OPC_LOAD};
	endfunction

	function automatic inst_t sw(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], `F3_WORD, imm[4:0], `OPC_STORE};
	endfunction

	function automatic inst_t beq(input int rs1, input int rs2, input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], `F3_ADD, off[4:1], off[11], `OPC_BRANCH};
	endfunction

	function automatic int word_index(input xlen_t byte_addr);
		return (byte_addr >> 2) % `MEM_WORDS;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// reference model, runs the loaded image in program order
	//////////////////////////////////////////////////////////////////////

	task automatic run_model;
		xlen_t regs [`REG_COUNT];
		xlen_t pc, next_pc, a, b, res, imm_i, imm_s, imm_b;
		inst_t inst;
		logic  writes, legal, stop;
		int    steps;
		for (int i = 0; i < `REG_COUNT; i++)
			regs[i] = '0;
		for (int i = 0; i < `MEM_WORDS; i++)
			ref_mem[i] = mem_model.read_word(i);
		exp_pc.delete();
		exp_idx.delete();
		exp_data.delete();
		exp_status = NO_ERROR;
		pc = `RESET_PC;
		stop = 1'b0;
		steps = 0;
		while (!stop && steps < RUN_LIMIT) begin
			inst    = ref_mem[word_index(pc)];
			a       = regs[inst[19:15]];
			b       = regs[inst[24:20]];
			imm_i   = {{20{inst[31]}}, inst[31:20]};
			imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			imm_b   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			next_pc = pc + 4;
			res     = '0;
			writes  = 1'b0;
			legal   = 1'b1;
			case (inst[6:0])
				`OPC_OP: begin
					writes = 1'b1;
					case ({inst[31:25], inst[14:12]})
						{`F7_BASE, `F3_ADD}: res = a + b;
						{`F7_SUB, `F3_ADD}:  res = a - b;
						{`F7_BASE, `F3_AND}: res = a & b;
						{`F7_BASE, `F3_OR}:  res = a | b;
						default:             legal = 1'b0;
					endcase
				end
				`OPC_OP_IMM: begin
					writes = 1'b1;
					legal  = (inst[14:12] == `F3_ADD);
					res    = a + imm_i;
				end
				`OPC_LOAD: begin
					writes = 1'b1;
					legal  = (inst[14:12] == `F3_WORD);
					res    = ref_mem[word_index(a + imm_i)];
				end
				`OPC_STORE: begin
					legal = (inst[14:12] == `F3_WORD);
					if (legal)
						ref_mem[word_index(a + imm_s)] = b;
				end
				`OPC_BRANCH: begin
					legal = (inst[14:12] == `F3_ADD);
					if (a == b)
						next_pc = pc + imm_b;
				end
				`OPC_SYSTEM: begin
					legal = (inst == `WFI_INST);
					stop  = legal;
				end
				default: legal = 1'b0;
			endcase
			if (!legal) begin   // the bad one never commits
				exp_status = ILLEGAL_INST;
				stop = 1'b1;
			end else begin
				exp_pc.push_back(pc);
				exp_idx.push_back(writes ? inst[11:7] : `ZERO_REG);
				exp_data.push_back(res);
				if (writes && inst[11:7] != `ZERO_REG)
					regs[inst[11:7]] = res;
				if (stop)
					exp_status = HALTED_ON_WFI;
				pc = next_pc;
			end
			steps++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// test flow
	//////////////////////////////////////////////////////////////////////

	task automatic start_test(input string name);
		current_test = name;
		prog.delete();
		@(posedge clock);
		#1 rst = 1'b1;
		@(posedge clock);
		#1;   // core is in reset from here
	endtask

	task automatic compare_commits;
		int n;
		checks++;
		if (got_pc.size() != exp_pc.size()) begin
			errors++;
			$display("%s committed %0d instructions where %0d were expected",
			         current_test, got_pc.size(), exp_pc.size());
		end
		n = (got_pc.size() < exp_pc.size()) ? got_pc.size() : exp_pc.size();
		for (int i = 0; i < n; i++) begin
			check_word($sformatf("commit_pc[%0d]", i), got_pc[i], exp_pc[i]);
			check_idx($sformatf("commit_wr_idx[%0d]", i), got_idx[i], exp_idx[i]);
			if (exp_idx[i] != `ZERO_REG)
				check_word($sformatf("commit_wr_data[%0d]", i), got_data[i], exp_data[i]);
		end
		check_status("error_status", error_status, exp_status);
	endtask

	// load, release reset, run until the core stops, then compare
	task automatic run_test;
		int cycles;
		mem_model.fill();
		for (int i = 0; i < prog.size(); i++)
			mem_model.write_word(i, prog[i]);
		run_model();
		got_pc.delete();
		got_idx.delete();
		got_data.delete();
		for (int i = 1; i < RESET_CYCLES; i++) begin
			@(posedge clock);
			check_idle();
		end
		#1 rst = 1'b0;
		@(posedge clock);
		check_idle();   // first edge out of reset
		cycles = 0;
		while (error_status == NO_ERROR && cycles < RUN_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		if (error_status == NO_ERROR) begin
			errors++;
			$display("%s did not stop within %0d cycles", current_test, RUN_LIMIT);
		end
		repeat (DRAIN_CYCLES) @(posedge clock);   // late commits would show here
		compare_commits();
	endtask

	task automatic test_forwarding;
		int imm_a, imm_b, imm_c;
		start_test("forwarding");
		imm_a = $urandom_range(4095);
		imm_b = $urandom_range(4095);
		imm_c = $urandom_range(4095);
		prog.push_back(addi(1, 0, imm_a));
		prog.push_back(addi(2, 1, imm_b));
		prog.push_back(r_type(`F7_BASE, `F3_ADD, 3, 1, 2));
		prog.push_back(r_type(`F7_SUB, `F3_ADD, 4, 3, 1));
		prog.push_back(r_type(`F7_BASE, `F3_AND, 5, 4, 3));
		prog.push_back(r_type(`F7_BASE, `F3_OR, 6, 5, 4));
		prog.push_back(r_type(`F7_BASE, `F3_ADD, 7, 6, 3));   // x3 via regfile
		prog.push_back(r_type(`F7_SUB, `F3_ADD, 8, 7, 2));
		prog.push_back(addi(0, 8, imm_c));
		prog.push_back(r_type(`F7_BASE, `F3_OR, 9, 0, 8));
		prog.push_back(`WFI_INST);
		run_test();
	endtask

	task automatic test_memory;
		int value;
		start_test("memory");
		value = $urandom_range(4095);
		prog.push_back(addi(1, 0, 'h200));
		prog.push_back(addi(2, 0, value));
		prog.push_back(sw(2, 1, 0));
		prog.push_back(lw(3, 1, 0));
		prog.push_back(r_type(`F7_BASE, `F3_ADD, 4, 3, 2));   // load-use
		prog.push_back(sw(4, 1, 4));
		prog.push_back(lw(5, 1, 4));
		prog.push_back(r_type(`F7_BASE, `F3_OR, 6, 5, 3));
		prog.push_back(`WFI_INST);
		run_test();
		check_word("mem[0x200]", mem_model.read_word(128), ref_mem[128]);
		check_word("mem[0x204]", mem_model.read_word(129), ref_mem[129]);
	endtask

	task automatic test_branches;
		start_test("branches");
		prog.push_back(addi(1, 0, 5));
		prog.push_back(addi(2, 0, 5));
		prog.push_back(beq(1, 2, 12));   // taken, skips two
		prog.push_back(addi(3, 0, 1));
		prog.push_back(addi(4, 0, 2));
		prog.push_back(addi(5, 0, 3));
		prog.push_back(beq(1, 5, 8));    // not taken
		prog.push_back(addi(6, 0, 4));
		prog.push_back(`WFI_INST);
		run_test();
	endtask

	task automatic test_wfi;
		start_test("wfi");
		prog.push_back(addi(1, 0, 9));
		prog.push_back(`WFI_INST);
		prog.push_back(addi(2, 0, 1));
		prog.push_back(sw(1, 0, 'h200));   // must never reach memory
		run_test();
		check_word("mem[0x200]", mem_model.read_word(128), ref_mem[128]);
	endtask

	task automatic test_illegal;
		start_test("illegal");
		prog.push_back(addi(1, 0, 'h7ff));
		prog.push_back(addi(2, 1, 3));
		prog.push_back(r_type(7'b0000001, `F3_ADD, 3, 1, 2));   // mul, not in subset
		prog.push_back(addi(4, 0, 1));
		prog.push_back(`WFI_INST);
		run_test();
	endtask

	initial begin
		rst    = 1'b1;
		errors = 0;
		checks = 0;
		seed   = $urandom(36);
		test_forwarding();
		test_memory();
		test_branches();
		test_wfi();
		test_illegal();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* tb/tb_memory.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_memory (
	input  logic              clock,
	input  rv_pkg::mem_cmd_e  command,
	input  rv_pkg::xlen_t     addr,
	input  rv_pkg::xlen_t     wdata,
	output rv_pkg::xlen_t     rdata
);
	import rv_pkg::*;

	xlen_t words [`MEM_WORDS];
	xlen_t next_rdata;

	function automatic int word_index(input xlen_t byte_addr);
		return (byte_addr >> 2) % `MEM_WORDS;   // wraps inside the model
	endfunction

	task automatic fill;
		for (int i = 0; i < `MEM_WORDS; i++)
			words[i] = {~i[7:0], i[7:0], 16'hffff};   // opcode 7f is never legal
	endtask

	task automatic write_word(input int index, input xlen_t value);
		words[index] = value;
	endtask

	function automatic xlen_t read_word(input int index);
		return words[index];
	endfunction

	initial begin
		rdata      = '0;
		next_rdata = '0;
	end

	// stores land at the edge, loads answer on the next cycle
	always @(posedge clock) begin
		if (command == BUS_STORE)
			words[word_index(addr)] = wdata;
		else if (command == BUS_LOAD)
			next_rdata = words[word_index(addr)];
		#1 rdata = next_rdata;
	end

endmodule

/* source/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
	input  logic              clock,
	input  logic              rst,
	input  rv_pkg::xlen_t     mem_rdata,
	output rv_pkg::mem_cmd_e  mem_command,
	output rv_pkg::xlen_t     mem_addr,
	output rv_pkg::xlen_t     mem_wdata,
	output logic              commit_valid,
	output logic              commit_wr_en,
	output rv_pkg::reg_idx_t  commit_wr_idx,
	output rv_pkg::xlen_t     commit_wr_data,
	output rv_pkg::xlen_t     commit_pc,
	output rv_pkg::error_e    error_status
);
	import rv_pkg::*;

	xlen_t    fetch_addr, rdata, if_pc, branch_target;
	xlen_t    data_addr, data_wdata;
	mem_cmd_e data_cmd;
	logic     fetch_grant, fetch_rvalid, load_rvalid, halted;
	inst_t    if_inst;
	logic     if_valid, stall, take_branch;
	xlen_t    id_pc, id_rs1_val, id_rs2_val, id_imm;
	reg_idx_t id_rs1, id_rs2, id_rd;
	alu_op_e  id_alu_op;
	logic     id_use_imm, id_rd_mem, id_wr_mem, id_branch, id_halt, id_illegal, id_valid;
	xlen_t    ex_result, ex_store_data, ex_pc;
	reg_idx_t ex_rd;
	logic     ex_rd_mem, ex_wr_mem, ex_halt, ex_illegal, ex_valid;

	//////////////////////////////////////////////////////////////////////
	// shared memory port
	//////////////////////////////////////////////////////////////////////

	bus_arbiter arbiter (.*);

	//////////////////////////////////////////////////////////////////////
	// pipeline stages
	//////////////////////////////////////////////////////////////////////

	fetch_unit fetch (.*);

	decode_regfile decode (
		.*,
		.flush   (take_branch),
		.wb_en   (commit_wr_en),
		.wb_idx  (commit_wr_idx),
		.wb_data (commit_wr_data)
	);

	execute_unit execute (
		.*,
		.wb_en   (commit_wr_en),
		.wb_idx  (commit_wr_idx),
		.wb_data (commit_wr_data)
	);

	mem_writeback memwb (   // drives the writeback port straight out
		.*,
		.wb_en   (commit_wr_en),
		.wb_idx  (commit_wr_idx),
		.wb_data (commit_wr_data)
	);

endmodule

/* source/mem_writeback.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module mem_writeback (
	input  logic              clock,
	input  logic              rst,
	input  rv_pkg::xlen_t     ex_result,
	input  rv_pkg::xlen_t     ex_store_data,
	input  rv_pkg::reg_idx_t  ex_rd,
	input  logic              ex_rd_mem,
	input  logic              ex_wr_mem,
	input  logic              ex_halt,
	input  logic              ex_illegal,
	input  logic              ex_valid,
	input  rv_pkg::xlen_t     ex_pc,
	input  logic              load_rvalid,
	input  rv_pkg::xlen_t     rdata,
	output rv_pkg::mem_cmd_e  data_cmd,
	output rv_pkg::xlen_t     data_addr,
	output rv_pkg::xlen_t     data_wdata,
	output logic              wb_en,
	output rv_pkg::reg_idx_t  wb_idx,
	output rv_pkg::xlen_t     wb_data,
	output logic              commit_valid,
	output rv_pkg::xlen_t     commit_pc,
	output rv_pkg::error_e    error_status,
	output logic              halted
);
	import rv_pkg::*;

	logic   wb_valid, wb_is_load, wb_halt, wb_illegal;
	xlen_t  wb_result;
	error_e err_q;

	// nothing younger than a halting instruction may touch memory
	always_comb begin
		data_cmd = BUS_NONE;
		if (ex_valid && !halted) begin
			if (ex_rd_mem)
				data_cmd = BUS_LOAD;
			else if (ex_wr_mem)
				data_cmd = BUS_STORE;
		end
	end
	assign data_addr  = ex_result;
	assign data_wdata = ex_store_data;

	//////////////////////////////////////////////////////////////////////
	// mem/wb register and writeback
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			wb_valid   <= 1'b0;
			wb_halt    <= 1'b0;
			wb_illegal <= 1'b0;
			err_q      <= NO_ERROR;
		end else begin
			wb_valid   <= ex_valid;
			wb_halt    <= ex_halt;
			wb_illegal <= ex_illegal;
			if (err_q == NO_ERROR && wb_valid && wb_illegal)
				err_q <= ILLEGAL_INST;
			else if (err_q == NO_ERROR && wb_valid && wb_halt)
				err_q <= HALTED_ON_WFI;
		end
	end

	always_ff @(posedge clock) begin
		wb_idx     <= ex_rd;
		wb_is_load <= ex_rd_mem;
		wb_result  <= ex_result;
		commit_pc  <= ex_pc;
	end

	assign halted       = (err_q != NO_ERROR) || (wb_valid && (wb_halt || wb_illegal));
	assign commit_valid = wb_valid && !wb_illegal && (err_q == NO_ERROR);
	assign wb_en        = commit_valid && (wb_idx != `ZERO_REG);
	assign wb_data      = (wb_is_load && load_rvalid) ? rdata : wb_result;
	assign error_status = err_q;   // sticky

endmodule

/* source/execute_unit.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module execute_unit (
	input  logic              clock,
	input  logic              rst,
	input  rv_pkg::xlen_t     id_pc,
	input  rv_pkg::xlen_t     id_rs1_val,
	input  rv_pkg::xlen_t     id_rs2_val,
	input  rv_pkg::xlen_t     id_imm,
	input  rv_pkg::reg_idx_t  id_rs1,
	input  rv_pkg::reg_idx_t  id_rs2,
	input  rv_pkg::reg_idx_t  id_rd,
	input  rv_pkg::alu_op_e   id_alu_op,
	input  logic              id_use_imm,
	input  logic              id_rd_mem,
	input  logic              id_wr_mem,
	input  logic              id_branch,
	input  logic              id_halt,
	input  logic              id_illegal,
	input  logic              id_valid,
	input  logic              wb_en,
	input  rv_pkg::reg_idx_t  wb_idx,
	input  rv_pkg::xlen_t     wb_data,
	output logic              take_branch,
	output rv_pkg::xlen_t     branch_target,
	output rv_pkg::xlen_t     ex_result,
	output rv_pkg::xlen_t     ex_store_data,
	output rv_pkg::reg_idx_t  ex_rd,
	output logic              ex_rd_mem,
	output logic              ex_wr_mem,
	output logic              ex_halt,
	output logic              ex_illegal,
	output logic              ex_valid,
	output rv_pkg::xlen_t     ex_pc
);
	import rv_pkg::*;

	fwd_sel_e sel_a, sel_b;
	xlen_t    op_a, rs2_fwd, op_b, result;

	// newest producer wins; a load in ex/mem never matches thanks to the stall
	function automatic fwd_sel_e pick(input reg_idx_t idx);
		if (idx == `ZERO_REG)
			return FWD_REG;
		if (ex_valid && !ex_rd_mem && ex_rd == idx)
			return FWD_EX;
		if (wb_en && wb_idx == idx)
			return FWD_WB;
		return FWD_REG;
	endfunction

	function automatic xlen_t operand(input fwd_sel_e sel, input xlen_t reg_val);
		case (sel)
			FWD_EX:  return ex_result;
			FWD_WB:  return wb_data;
			default: return reg_val;
		endcase
	endfunction

	always_comb begin
		sel_a   = pick(id_rs1);
		sel_b   = pick(id_rs2);
		op_a    = operand(sel_a, id_rs1_val);
		rs2_fwd = operand(sel_b, id_rs2_val);
		op_b    = id_use_imm ? id_imm : rs2_fwd;
	end

	always_comb begin
		case (id_alu_op)
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR:  result = op_a | op_b;
			default: result = op_a + op_b;   // add, addi, address
		endcase
	end

	// beq resolves here
	assign take_branch   = id_valid && id_branch && (op_a == rs2_fwd);
	assign branch_target = id_pc + id_imm;

	//////////////////////////////////////////////////////////////////////
	// ex/mem register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			ex_valid   <= 1'b0;
			ex_rd      <= `ZERO_REG;
			ex_rd_mem  <= 1'b0;
			ex_wr_mem  <= 1'b0;
			ex_halt    <= 1'b0;
			ex_illegal <= 1'b0;
		end else begin
			ex_valid   <= id_valid;
			ex_rd      <= id_rd;
			ex_rd_mem  <= id_rd_mem;
			ex_wr_mem  <= id_wr_mem;
			ex_halt    <= id_halt;
			ex_illegal <= id_illegal;
		end
	end

	always_ff @(posedge clock) begin
		ex_result     <= result;
		ex_store_data <= rs2_fwd;
		ex_pc         <= id_pc;
	end

endmodule

/* source/decode_regfile.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module decode_regfile (
	input  logic              clock,
	input  logic              rst,
	input  rv_pkg::inst_t     if_inst,
	input  rv_pkg::xlen_t     if_pc,
	input  logic              if_valid,
	input  logic              flush,
	input  logic              wb_en,
	input  rv_pkg::reg_idx_t  wb_idx,
	input  rv_pkg::xlen_t     wb_data,
	output logic              stall,
	output rv_pkg::xlen_t     id_pc,
	output rv_pkg::xlen_t     id_rs1_val,
	output rv_pkg::xlen_t     id_rs2_val,
	output rv_pkg::xlen_t     id_imm,
	output rv_pkg::reg_idx_t  id_rs1,
	output rv_pkg::reg_idx_t  id_rs2,
	output rv_pkg::reg_idx_t  id_rd,
	output rv_pkg::alu_op_e   id_alu_op,
	output logic              id_use_imm,
	output logic              id_rd_mem,
	output logic              id_wr_mem,
	output logic              id_branch,
	output logic              id_halt,
	output logic              id_illegal,
	output logic              id_valid
);
	import rv_pkg::*;

	xlen_t    regs [`REG_COUNT];
	reg_idx_t rs1, rs2, rd;
	xlen_t    imm, rs1_val, rs2_val;
	alu_op_e  alu_op;
	logic     use_imm, rd_mem, wr_mem, branch, halt, illegal;
	logic     live;

	//////////////////////////////////////////////////////////////////////
	// decoder
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		rs1     = if_inst[19:15];
		rs2     = if_inst[24:20];
		rd      = if_inst[11:7];
		imm     = {{20{if_inst[31]}}, if_inst[31:20]};   // i-type
		alu_op  = ALU_ADD;
		use_imm = 1'b0;
		rd_mem  = 1'b0;
		wr_mem  = 1'b0;
		branch  = 1'b0;
		halt    = 1'b0;
		illegal = 1'b0;
		case (if_inst[6:0])
			`OPC_OP: begin
				if (if_inst[31:25] == `F7_BASE && if_inst[14:12] == `F3_ADD)
					alu_op = ALU_ADD;
				else if (if_inst[31:25] == `F7_SUB && if_inst[14:12] == `F3_ADD)
					alu_op = ALU_SUB;
				else if (if_inst[31:25] == `F7_BASE && if_inst[14:12] == `F3_AND)
					alu_op = ALU_AND;
				else if (if_inst[31:25] == `F7_BASE && if_inst[14:12] == `F3_OR)
					alu_op = ALU_OR;
				else
					illegal = 1'b1;
			end
			`OPC_OP_IMM, `OPC_LOAD: begin
				use_imm = 1'b1;
				rs2     = `ZERO_REG;   // no second source
				rd_mem  = (if_inst[6:0] == `OPC_LOAD);
				if (if_inst[14:12] != (rd_mem ? `F3_WORD : `F3_ADD))
					illegal = 1'b1;
			end
			`OPC_STORE: begin
				use_imm = 1'b1;
				wr_mem  = 1'b1;
				rd      = `ZERO_REG;
				imm     = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
				illegal = (if_inst[14:12] != `F3_WORD);
			end
			`OPC_BRANCH: begin
				branch  = 1'b1;
				rd      = `ZERO_REG;
				imm     = {{19{if_inst[31]}}, if_inst[31], if_inst[7],
				           if_inst[30:25], if_inst[11:8], 1'b0};
				illegal = (if_inst[14:12] != `F3_ADD);
			end
			`OPC_SYSTEM: begin
				halt    = (if_inst == `WFI_INST);
				illegal = !halt;
				rd      = `ZERO_REG;
			end
			default: illegal = 1'b1;
		endcase
		if (illegal || halt) begin   // kill every side effect
			rs1    = `ZERO_REG;
			rs2    = `ZERO_REG;
			rd     = `ZERO_REG;
			rd_mem = 1'b0;
			wr_mem = 1'b0;
			branch = 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// register file, write-through on a same-cycle writeback
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		rs1_val = regs[rs1];
		rs2_val = regs[rs2];
		if (wb_en && wb_idx == rs1)
			rs1_val = wb_data;
		if (wb_en && wb_idx == rs2)
			rs2_val = wb_data;
		if (rs1 == `ZERO_REG)
			rs1_val = '0;
		if (rs2 == `ZERO_REG)
			rs2_val = '0;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wb_en && wb_idx != `ZERO_REG) begin
			regs[wb_idx] <= wb_data;
		end
	end

	// load-use: the load in id/ex has no data until writeback
	assign stall = if_valid && id_valid && id_rd_mem && id_rd != `ZERO_REG &&
	               (id_rd == rs1 || id_rd == rs2);
	assign live = if_valid && !stall && !flush;

	//////////////////////////////////////////////////////////////////////
	// id/ex register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			id_valid   <= 1'b0;
			id_rd      <= `ZERO_REG;
			id_rd_mem  <= 1'b0;
			id_wr_mem  <= 1'b0;
			id_branch  <= 1'b0;
			id_halt    <= 1'b0;
			id_illegal <= 1'b0;
		end else begin   // bubble on stall or flush
			id_valid   <= live;
			id_rd      <= live ? rd : `ZERO_REG;
			id_rd_mem  <= live && rd_mem;
			id_wr_mem  <= live && wr_mem;
			id_branch  <= live && branch;
			id_halt    <= live && halt;
			id_illegal <= live && illegal;
		end
	end

	always_ff @(posedge clock) begin
		id_pc      <= if_pc;
		id_rs1_val <= rs1_val;
		id_rs2_val <= rs2_val;
		id_imm     <= imm;
		id_rs1     <= rs1;
		id_rs2     <= rs2;
		id_alu_op  <= alu_op;
		id_use_imm <= use_imm;
	end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module fetch_unit (
	input  logic           clock,
	input  logic           rst,
	input  logic           fetch_grant,
	input  logic           fetch_rvalid,
	input  rv_pkg::xlen_t  rdata,
	input  logic           stall,
	input  logic           take_branch,
	input  rv_pkg::xlen_t  branch_target,
	output rv_pkg::xlen_t  fetch_addr,
	output rv_pkg::inst_t  if_inst,
	output rv_pkg::xlen_t  if_pc,
	output logic           if_valid
);
	import rv_pkg::*;

	xlen_t pc;
	xlen_t req_pc;      // address of the fetch in flight
	logic  req_valid;   // cleared on redirect, so a stale answer is dropped
	inst_t hold_inst;   // answer that came back while decode stalled
	xlen_t hold_pc;
	logic  hold_valid;
	logic  accept;
	logic  answer;

	assign fetch_addr = pc;
	assign accept = fetch_grant && !stall && !take_branch;
	assign answer = fetch_rvalid && req_valid;

	always_ff @(posedge clock) begin
		if (rst) begin
			pc         <= `RESET_PC;
			req_valid  <= 1'b0;
			hold_valid <= 1'b0;
			if_valid   <= 1'b0;
		end else if (take_branch) begin   // squash everything younger
			pc         <= branch_target;
			req_valid  <= 1'b0;
			hold_valid <= 1'b0;
			if_valid   <= 1'b0;
		end else begin
			if (accept)
				pc <= pc + `XLEN'd4;
			req_valid <= accept;
			if (!stall) begin
				if_valid   <= hold_valid || answer;
				hold_valid <= 1'b0;
			end else if (answer) begin
				hold_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			req_pc <= pc;
		if (!stall) begin
			if_inst <= hold_valid ? hold_inst : rdata;
			if_pc   <= hold_valid ? hold_pc : req_pc;
		end else if (answer) begin
			hold_inst <= rdata;
			hold_pc   <= req_pc;
		end
	end

endmodule

/* source/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
	input  logic              clock,
	input  logic              rst,
	input  rv_pkg::xlen_t     fetch_addr,
	input  rv_pkg::mem_cmd_e  data_cmd,
	input  rv_pkg::xlen_t     data_addr,
	input  rv_pkg::xlen_t     data_wdata,
	input  rv_pkg::xlen_t     mem_rdata,
	input  logic              halted,
	output rv_pkg::mem_cmd_e  mem_command,
	output rv_pkg::xlen_t     mem_addr,
	output rv_pkg::xlen_t     mem_wdata,
	output logic              fetch_grant,
	output logic              fetch_rvalid,
	output logic              load_rvalid,
	output rv_pkg::xlen_t     rdata
);
	import rv_pkg::*;

	logic running;   // low in reset and the first cycle out of it

	always_comb begin
		mem_command = BUS_NONE;
		mem_addr    = fetch_addr;
		mem_wdata   = data_wdata;
		fetch_grant = 1'b0;
		if (running && !halted) begin
			if (data_cmd != BUS_NONE) begin   // data side wins the port
				mem_command = data_cmd;
				mem_addr    = data_addr;
			end else begin
				mem_command = BUS_LOAD;
				fetch_grant = 1'b1;
			end
		end
	end

	// remember who owned this load cycle, data comes back next cycle
	always_ff @(posedge clock) begin
		if (rst) begin
			running      <= 1'b0;
			fetch_rvalid <= 1'b0;
			load_rvalid  <= 1'b0;
		end else begin
			running      <= 1'b1;
			fetch_rvalid <= fetch_grant;
			load_rvalid  <= (mem_command == BUS_LOAD) && !fetch_grant;
		end
	end

	assign rdata = mem_rdata;

endmodule

/* source/rv_pkg.sv */
`include "rv_consts.svh"

package rv_pkg;

	typedef logic [`XLEN-1:0] xlen_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_idx_t;

	// command on the shared memory port
	typedef enum logic [1:0] {
		BUS_NONE  = 2'd0,
		BUS_LOAD  = 2'd1,
		BUS_STORE = 2'd2
	} mem_cmd_e;

	typedef enum logic [1:0] {
		ALU_ADD = 2'd0,
		ALU_SUB = 2'd1,
		ALU_AND = 2'd2,
		ALU_OR  = 2'd3
	} alu_op_e;

	// operand source in execute
	typedef enum logic [1:0] {
		FWD_REG = 2'd0,   // register file value from decode
		FWD_EX  = 2'd1,   // ex/mem alu result
		FWD_WB  = 2'd2    // value being written back
	} fwd_sel_e;

	typedef enum logic [1:0] {
		NO_ERROR      = 2'd0,
		ILLEGAL_INST  = 2'd1,
		HALTED_ON_WFI = 2'd2
	} error_e;

endpackage

/* source/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN       32
`define REG_COUNT  32
`define RESET_PC   32'h0000_0000
`define NOP        32'h0000_0013   // addi x0, x0, 0
`define ZERO_REG   5'd0
`define MEM_WORDS  256

// major opcodes of the supported subset
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_SYSTEM  7'b1110011

`define F3_ADD     3'b000   // also addi, beq
`define F3_AND     3'b111
`define F3_OR      3'b110
`define F3_WORD    3'b010   // lw, sw
`define F7_BASE    7'b0000000
`define F7_SUB     7'b0100000
`define WFI_INST   32'h1050_0073

`endif
